/* verilog/te_trace_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// instruction-side encodings and limits of the trace encoder
// imported by the window, timer, branch map and testbench
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package te_trace_pkg;

    // retired instruction fields
    localparam int unsigned XLEN   = 32;
    localparam int unsigned PRIV_W = 2;

    // itype codes follow the e-trace ingress numbering
    typedef enum logic [2:0] {
        ITYPE_NORMAL           = 3'd0,
        ITYPE_EXCEPTION        = 3'd1,
        ITYPE_BRANCH_NOT_TAKEN = 3'd4,
        ITYPE_BRANCH_TAKEN     = 3'd5,
        ITYPE_UNINF_JUMP       = 3'd6
    } itype_e;

    // branch map capacity and count width
    localparam int unsigned BMAP_DEPTH = 31;
    localparam int unsigned BMAP_CNT_W = 5;

    // traced instructions between forced syncs
    localparam int unsigned RESYNC_MAX = 64;
    localparam int unsigned RESYNC_W   = 7;

endpackage

/* verilog/te_packet_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// packet format encodings and the priority FSM states
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package te_packet_pkg;

    // format 0 is not produced by this encoder
    typedef enum logic [1:0] {
        FMT_ADDR_BRANCH = 2'd1,
        FMT_ADDR_ONLY   = 2'd2,
        FMT_SYNC        = 2'd3
    } format_e;

    // only meaningful with FMT_SYNC
    typedef enum logic [1:0] {
        SF_START = 2'd0,
        SF_TRAP  = 2'd1
    } subformat_e;

    // qualification state
    typedef enum logic {
        ST_IDLE    = 1'b0,
        ST_TRACING = 1'b1
    } te_state_e;

endpackage

/* verilog/te_stage_window.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// nc/tc/lc instruction window, shifted on each retired instruction
// decodes per-stage event flags for the priority logic
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module te_stage_window
    import te_trace_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              inst_valid_i,
    input  logic [XLEN-1:0]   inst_iaddr_i,
    input  itype_e            inst_itype_i,
    input  logic [PRIV_W-1:0] inst_priv_i,
    input  logic              qualified_i,
    output logic              advance_o,
    output logic              tc_valid_o,
    output logic              tc_qualified_o,
    output logic              nc_valid_o,
    output logic              nc_qualified_o,
    output logic              lc_exception_o,
    output logic              lc_updiscon_o,
    output logic              tc_privchange_o,
    output logic              nc_exception_o,
    output logic              nc_privchange_o,
    output logic              tc_is_branch_o,
    output logic              tc_branch_taken_o,
    output logic [XLEN-1:0]   tc_iaddr_o
);

    logic              nc_valid_q, tc_valid_q, lc_valid_q;
    logic [XLEN-1:0]   nc_iaddr_q, tc_iaddr_q;
    itype_e            nc_itype_q, tc_itype_q, lc_itype_q;
    logic [PRIV_W-1:0] nc_priv_q, tc_priv_q, lc_priv_q;
    logic              nc_qual_q, tc_qual_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            nc_valid_q <= 1'b0;
            tc_valid_q <= 1'b0;
            lc_valid_q <= 1'b0;
        end else if (inst_valid_i) begin
            nc_valid_q <= 1'b1;
            tc_valid_q <= nc_valid_q;
            lc_valid_q <= tc_valid_q;
        end
    end

    // stage payload
    always_ff @(posedge clk) begin
        if (inst_valid_i) begin
            nc_iaddr_q <= inst_iaddr_i;
            nc_itype_q <= inst_itype_i;
            nc_priv_q  <= inst_priv_i;
            nc_qual_q  <= qualified_i;
            tc_iaddr_q <= nc_iaddr_q;
            tc_itype_q <= nc_itype_q;
            tc_priv_q  <= nc_priv_q;
            tc_qual_q  <= nc_qual_q;
            lc_itype_q <= tc_itype_q;
            lc_priv_q  <= tc_priv_q;
        end
    end

    assign advance_o      = inst_valid_i;
    assign tc_valid_o     = tc_valid_q;
    assign nc_valid_o     = nc_valid_q;
    assign tc_qualified_o = tc_valid_q & tc_qual_q;
    assign nc_qualified_o = nc_valid_q & nc_qual_q;

    assign lc_exception_o  = lc_valid_q & (lc_itype_q == ITYPE_EXCEPTION);
    assign lc_updiscon_o   = lc_valid_q & (lc_itype_q == ITYPE_UNINF_JUMP);
    assign nc_exception_o  = nc_valid_q & (nc_itype_q == ITYPE_EXCEPTION);
    assign tc_privchange_o = tc_valid_q & lc_valid_q & (tc_priv_q != lc_priv_q);
    assign nc_privchange_o = nc_valid_q & tc_valid_q & (nc_priv_q != tc_priv_q);

    // only traced branches go into the map
    assign tc_is_branch_o    = tc_qualified_o &
                               ((tc_itype_q == ITYPE_BRANCH_TAKEN) ||
                                (tc_itype_q == ITYPE_BRANCH_NOT_TAKEN));
    assign tc_branch_taken_o = tc_itype_q == ITYPE_BRANCH_TAKEN;
    assign tc_iaddr_o        = tc_iaddr_q;

endmodule

/* verilog/te_priority.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// qualification FSM and packet format priority chain
// decides on each advance whether tc produces a packet
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module te_priority
    import te_packet_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n_i,
    input  logic       advance_i,
    input  logic       tc_valid_i,
    input  logic       tc_qualified_i,
    input  logic       nc_valid_i,
    input  logic       nc_qualified_i,
    input  logic       lc_exception_i,
    input  logic       lc_updiscon_i,
    input  logic       tc_privchange_i,
    input  logic       nc_exception_i,
    input  logic       nc_privchange_i,
    input  logic       bmap_empty_i,
    input  logic       bmap_full_i,
    input  logic       resync_pending_i,
    output logic       emit_o,
    output format_e    format_o,
    output subformat_e subformat_o,
    output logic       resync_rst_o
);

    te_state_e state_q;
    logic      tc_traced;
    logic      tc_final;
    logic      emit_c;
    logic      resync_c;
    format_e   addr_fmt;

    // the window gates qualified with the tc valid bit
    assign tc_traced = tc_qualified_i;
    // tc is the last qualified instruction
    assign tc_final  = ~(nc_valid_i & nc_qualified_i);
    assign addr_fmt  = bmap_empty_i ? FMT_ADDR_ONLY : FMT_ADDR_BRANCH;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= ST_IDLE;
        end else if (advance_i) begin
            state_q <= tc_traced ? ST_TRACING : ST_IDLE;
        end
    end

    // first matching rule wins
    always_comb begin
        emit_c      = 1'b0;
        resync_c    = 1'b0;
        format_o    = FMT_ADDR_ONLY;
        subformat_o = SF_START;
        if (tc_traced) begin
            emit_c = 1'b1;
            if (state_q == ST_IDLE || tc_privchange_i) begin
                format_o = FMT_SYNC;
                resync_c = 1'b1;
            end else if (lc_exception_i) begin
                // tc is the trap handler
                format_o    = FMT_SYNC;
                subformat_o = SF_TRAP;
            end else if (resync_pending_i && bmap_empty_i) begin
                format_o = FMT_SYNC;
                resync_c = 1'b1;
            end else if (lc_updiscon_i) begin
                format_o = addr_fmt;
            end else if (resync_pending_i) begin
                // branches go out first and the sync follows on a later decision
                format_o = FMT_ADDR_BRANCH;
            end else if (tc_final || nc_exception_i || nc_privchange_i) begin
                format_o = addr_fmt;
            end else if (bmap_full_i) begin
                format_o = FMT_ADDR_BRANCH;
            end else begin
                emit_c = 1'b0;
            end
        end
    end

    assign emit_o       = advance_i & emit_c;
    assign resync_rst_o = advance_i & resync_c;

    a_emit_needs_tc : assert property (@(posedge clk) disable iff (!rst_n_i)
        emit_o |-> tc_valid_i)
        else $error("packet decided without a valid tc instruction");

    a_emit_format : assert property (@(posedge clk) disable iff (!rst_n_i)
        emit_o |-> format_o != 2'd0)
        else $error("packet decided with format 0");

endmodule

/* verilog/te_resync_timer.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// saturating count of traced instructions since the last sync
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module te_resync_timer
    import te_trace_pkg::*;
(
    input  logic clk,
    input  logic rst_n_i,
    input  logic advance_i,
    input  logic tc_qualified_i,
    input  logic resync_rst_i,
    output logic resync_pending_o
);

    logic [RESYNC_W-1:0] count_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            count_q <= '0;
        end else if (advance_i) begin
            if (resync_rst_i) begin
                count_q <= '0;
            end else if (tc_qualified_i && !resync_pending_o) begin
                count_q <= count_q + 1'b1;
            end
        end
    end

    assign resync_pending_o = count_q == RESYNC_W'(RESYNC_MAX);

    a_count_bound : assert property (@(posedge clk) disable iff (!rst_n_i)
        count_q <= RESYNC_W'(RESYNC_MAX))
        else $error("resync count above limit");

endmodule

/* verilog/te_branch_map.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// branch outcome map, oldest outcome in bit 0
// outputs include the pending tc bit and clear after a packet
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module te_branch_map
    import te_trace_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  advance_i,
    input  logic                  tc_is_branch_i,
    input  logic                  tc_branch_taken_i,
    input  logic                  flush_i,
    output logic [BMAP_DEPTH-1:0] bmap_o,
    output logic [BMAP_CNT_W-1:0] bmap_count_o,
    output logic                  bmap_empty_o,
    output logic                  bmap_full_o
);

    logic [BMAP_DEPTH-1:0] bmap_q;
    logic [BMAP_CNT_W-1:0] count_q;

    // stored map plus the tc outcome, 1 = not taken
    always_comb begin
        bmap_o = bmap_q;
        if (tc_is_branch_i) begin
            bmap_o[count_q] = ~tc_branch_taken_i;
        end
    end

    assign bmap_count_o = count_q + BMAP_CNT_W'(tc_is_branch_i);
    assign bmap_empty_o = bmap_count_o == '0;
    assign bmap_full_o  = bmap_count_o == BMAP_CNT_W'(BMAP_DEPTH);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            bmap_q  <= '0;
            count_q <= '0;
        end else if (advance_i) begin
            if (flush_i) begin
                // tc bit already went out with the packet
                bmap_q  <= '0;
                count_q <= '0;
            end else begin
                bmap_q  <= bmap_o;
                count_q <= bmap_count_o;
            end
        end
    end

    // a full view always forces a packet, so the stored map never fills
    a_count_bound : assert property (@(posedge clk) disable iff (!rst_n_i)
        count_q < BMAP_CNT_W'(BMAP_DEPTH))
        else $error("branch map stored count reached capacity");

endmodule

/* verilog/te_packet_emitter.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// packet output register, one-cycle valid per decided packet
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module te_packet_emitter
    import te_trace_pkg::*;
    import te_packet_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  advance_i,
    input  logic                  emit_i,
    input  format_e               format_i,
    input  subformat_e            subformat_i,
    input  logic [XLEN-1:0]       iaddr_i,
    input  logic [BMAP_DEPTH-1:0] bmap_i,
    input  logic [BMAP_CNT_W-1:0] bmap_count_i,
    output logic                  packet_valid_o,
    output format_e               packet_format_o,
    output subformat_e            packet_subformat_o,
    output logic [XLEN-1:0]       packet_address_o,
    output logic [BMAP_CNT_W-1:0] packet_branches_o,
    output logic [BMAP_DEPTH-1:0] packet_branch_map_o
);

    logic capture;
    logic is_sync;

    assign capture = advance_i & emit_i;
    assign is_sync = format_i == FMT_SYNC;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            packet_valid_o <= 1'b0;
        end else begin
            packet_valid_o <= capture;
        end
    end

    // fields hold until the next packet
    always_ff @(posedge clk) begin
        if (capture) begin
            packet_format_o    <= format_i;
            packet_subformat_o <= subformat_i;
            packet_address_o   <= iaddr_i;
            // sync packets carry no branch information
            packet_branches_o   <= is_sync ? '0 : bmap_count_i;
            packet_branch_map_o <= is_sync ? '0 : bmap_i;
        end
    end

endmodule

/* verilog/te_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// trace encoder top, retired instructions in and packets out
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module te_top
    import te_trace_pkg::*;
    import te_packet_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  inst_valid_i,
    input  logic [XLEN-1:0]       inst_iaddr_i,
    input  itype_e                inst_itype_i,
    input  logic [PRIV_W-1:0]     inst_priv_i,
    input  logic                  qualified_i,
    output logic                  packet_valid_o,
    output format_e               packet_format_o,
    output subformat_e            packet_subformat_o,
    output logic [XLEN-1:0]       packet_address_o,
    output logic [BMAP_CNT_W-1:0] packet_branches_o,
    output logic [BMAP_DEPTH-1:0] packet_branch_map_o
);

    logic                  advance;
    logic                  tc_valid, tc_qualified, nc_valid, nc_qualified;
    logic                  lc_exception, lc_updiscon, tc_privchange;
    logic                  nc_exception, nc_privchange;
    logic                  tc_is_branch, tc_branch_taken;
    logic [XLEN-1:0]       tc_iaddr;
    logic                  emit, resync_rst, resync_pending;
    format_e               format;
    subformat_e            subformat;
    logic [BMAP_DEPTH-1:0] bmap;
    logic [BMAP_CNT_W-1:0] bmap_count;
    logic                  bmap_empty, bmap_full;

    te_stage_window i_window (
        .clk, .rst_n_i, .inst_valid_i, .inst_iaddr_i, .inst_itype_i, .inst_priv_i,
        .qualified_i,
        .advance_o(advance), .tc_valid_o(tc_valid), .tc_qualified_o(tc_qualified),
        .nc_valid_o(nc_valid), .nc_qualified_o(nc_qualified),
        .lc_exception_o(lc_exception), .lc_updiscon_o(lc_updiscon),
        .tc_privchange_o(tc_privchange), .nc_exception_o(nc_exception),
        .nc_privchange_o(nc_privchange), .tc_is_branch_o(tc_is_branch),
        .tc_branch_taken_o(tc_branch_taken), .tc_iaddr_o(tc_iaddr)
    );

    te_priority i_priority (
        .clk, .rst_n_i, .advance_i(advance), .tc_valid_i(tc_valid),
        .tc_qualified_i(tc_qualified), .nc_valid_i(nc_valid),
        .nc_qualified_i(nc_qualified), .lc_exception_i(lc_exception),
        .lc_updiscon_i(lc_updiscon), .tc_privchange_i(tc_privchange),
        .nc_exception_i(nc_exception), .nc_privchange_i(nc_privchange),
        .bmap_empty_i(bmap_empty), .bmap_full_i(bmap_full),
        .resync_pending_i(resync_pending),
        .emit_o(emit), .format_o(format), .subformat_o(subformat),
        .resync_rst_o(resync_rst)
    );

    te_resync_timer i_resync_timer (
        .clk, .rst_n_i, .advance_i(advance), .tc_qualified_i(tc_qualified),
        .resync_rst_i(resync_rst), .resync_pending_o(resync_pending)
    );

    // a packet always flushes the map
    te_branch_map i_branch_map (
        .clk, .rst_n_i, .advance_i(advance), .tc_is_branch_i(tc_is_branch),
        .tc_branch_taken_i(tc_branch_taken), .flush_i(emit),
        .bmap_o(bmap), .bmap_count_o(bmap_count), .bmap_empty_o(bmap_empty),
        .bmap_full_o(bmap_full)
    );

    te_packet_emitter i_emitter (
        .clk, .rst_n_i, .advance_i(advance), .emit_i(emit), .format_i(format),
        .subformat_i(subformat), .iaddr_i(tc_iaddr), .bmap_i(bmap),
        .bmap_count_i(bmap_count),
        .packet_valid_o, .packet_format_o, .packet_subformat_o, .packet_address_o,
        .packet_branches_o, .packet_branch_map_o
    );

endmodule

/* dv/te_ref_model.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// reference model of the trace encoder, included inside the testbench module
// model_advance runs once per instruction, before the edge that takes it
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef TE_REF_MODEL_SVH
`define TE_REF_MODEL_SVH

// stage indices into the model window
localparam int NC = 0;
localparam int TC = 1;
localparam int LC = 2;

logic              m_vld  [3];
logic [XLEN-1:0]   m_addr [3];
itype_e            m_type [3];
logic [PRIV_W-1:0] m_priv [3];
logic              m_qual [3];
logic              m_tracing;
int unsigned       m_resync_cnt;
// outcomes in program order, 1 = not taken
bit                m_branches[$];
// expected packets as {format, subformat, address, count, map}
logic [4+XLEN+BMAP_CNT_W+BMAP_DEPTH-1:0] exp_q[$];

task automatic model_reset();
    for (int s = NC; s <= LC; s++) begin
        m_vld[s]  = 1'b0;
        m_addr[s] = '0;
        m_type[s] = ITYPE_NORMAL;
        m_priv[s] = '0;
        m_qual[s] = 1'b0;
    end
    m_tracing    = 1'b0;
    m_resync_cnt = 0;
    m_branches.delete();
    exp_q.delete();
endtask

task automatic model_advance(input logic [XLEN-1:0] addr, input itype_e itype,
                             input logic [PRIV_W-1:0] priv, input logic qual);
    logic                  tc_on, nc_on, pending, emit, sync_rst;
    logic                  lc_trap, lc_jump, nc_trap, tc_priv_chg, nc_priv_chg;
    logic [1:0]            fmt, sf, addr_fmt;
    logic [BMAP_CNT_W-1:0] cnt;
    logic [BMAP_DEPTH-1:0] map_bits;
    bit                    view[$];

    tc_on       = m_vld[TC] && m_qual[TC];
    nc_on       = m_vld[NC] && m_qual[NC];
    lc_trap     = m_vld[LC] && m_type[LC] == ITYPE_EXCEPTION;
    lc_jump     = m_vld[LC] && m_type[LC] == ITYPE_UNINF_JUMP;
    nc_trap     = m_vld[NC] && m_type[NC] == ITYPE_EXCEPTION;
    tc_priv_chg = m_vld[TC] && m_vld[LC] && m_priv[TC] != m_priv[LC];
    nc_priv_chg = m_vld[NC] && m_vld[TC] && m_priv[NC] != m_priv[TC];
    pending     = m_resync_cnt == RESYNC_MAX;

    // the packet carries the outcome of tc itself
    view = m_branches;
    if (tc_on && m_type[TC] == ITYPE_BRANCH_TAKEN) begin
        view.push_back(1'b0);
    end
    if (tc_on && m_type[TC] == ITYPE_BRANCH_NOT_TAKEN) begin
        view.push_back(1'b1);
    end
    addr_fmt = (view.size() == 0) ? FMT_ADDR_ONLY : FMT_ADDR_BRANCH;

    emit     = tc_on;
    sync_rst = 1'b0;
    fmt      = FMT_ADDR_ONLY;
    sf       = SF_START;
    if (!tc_on) begin
        emit = 1'b0;
    end else if (!m_tracing || tc_priv_chg) begin
        fmt      = FMT_SYNC;
        sync_rst = 1'b1;
    end else if (lc_trap) begin
        fmt = FMT_SYNC;
        sf  = SF_TRAP;
    end else if (pending && view.size() == 0) begin
        fmt      = FMT_SYNC;
        sync_rst = 1'b1;
    end else if (lc_jump) begin
        fmt = addr_fmt;
    end else if (pending) begin
        fmt = FMT_ADDR_BRANCH;
    end else if (!nc_on || nc_trap || nc_priv_chg) begin
        fmt = addr_fmt;
    end else if (view.size() == BMAP_DEPTH) begin
        fmt = FMT_ADDR_BRANCH;
    end else begin
        emit = 1'b0;
    end

    if (emit) begin
        cnt      = '0;
        map_bits = '0;
        if (fmt != FMT_SYNC) begin
            cnt = BMAP_CNT_W'(view.size());
            foreach (view[i]) begin
                map_bits[i] = view[i];
            end
        end
        exp_q.push_back({fmt, sf, m_addr[TC], cnt, map_bits});
    end

    // state, timer and map after the decision
    m_tracing = tc_on;
    if (sync_rst) begin
        m_resync_cnt = 0;
    end else if (tc_on && !pending) begin
        m_resync_cnt++;
    end
    if (emit) begin
        m_branches.delete();
    end else begin
        m_branches = view;
    end

    for (int s = LC; s > NC; s--) begin
        m_vld[s]  = m_vld[s-1];
        m_addr[s] = m_addr[s-1];
        m_type[s] = m_type[s-1];
        m_priv[s] = m_priv[s-1];
        m_qual[s] = m_qual[s-1];
    end
    m_vld[NC]  = 1'b1;
    m_addr[NC] = addr;
    m_type[NC] = itype;
    m_priv[NC] = priv;
    m_qual[NC] = qual;
endtask

`endif

/* dv/tb_te_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for te_top with a seeded random instruction stream in six tests
// every packet is compared with the included reference model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module tb_te_top
    import te_trace_pkg::*;
    import te_packet_pkg::*;
();

    localparam int N_TESTS = 6;
    localparam int N_INSTR = 400;
    // six tests at 3/4 density with a margin of 2
    localparam int TIMEOUT_CYCLES = N_TESTS * N_INSTR * 4 / 3 * 2;

    logic                  clk;
    logic                  rst_n_i;
    logic                  inst_valid_i;
    logic [XLEN-1:0]       inst_iaddr_i;
    itype_e                inst_itype_i;
    logic [PRIV_W-1:0]     inst_priv_i;
    logic                  qualified_i;
    logic                  packet_valid_o;
    format_e               packet_format_o;
    subformat_e            packet_subformat_o;
    logic [XLEN-1:0]       packet_address_o;
    logic [BMAP_CNT_W-1:0] packet_branches_o;
    logic [BMAP_DEPTH-1:0] packet_branch_map_o;

    string           test_name;
    int              err_count;
    int              pkt_count;
    int              tests_failed;
    int              cycle_count;
    int              qual_left;
    logic [XLEN-1:0] pc;

    `include "te_ref_model.svh"

    te_top i_te_top (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: run still going after %0d cycles", TIMEOUT_CYCLES);
        $display("Test failed");
        $finish;
    end

    task automatic check_field(input string field, input logic [31:0] exp_val,
                               input logic [31:0] act_val);
        if (act_val !== exp_val) begin
            $display("error %s %s: expected %h actual %h", test_name, field, exp_val, act_val);
            err_count++;
        end
    endtask

    // compares the packet of the edge just passed
    task automatic check_output();
        logic [1:0]            e_fmt;
        logic [1:0]            e_sf;
        logic [XLEN-1:0]       e_addr;
        logic [BMAP_CNT_W-1:0] e_cnt;
        logic [BMAP_DEPTH-1:0] e_map;

        if (packet_valid_o && exp_q.size() == 0) begin
            $display("%s: DUT sent a packet for %h but the model decided none",
                     test_name, packet_address_o);
            err_count++;
        end else if (packet_valid_o) begin
            {e_fmt, e_sf, e_addr, e_cnt, e_map} = exp_q.pop_front();
            check_field("format", 32'(e_fmt), 32'(packet_format_o));
            check_field("subformat", 32'(e_sf), 32'(packet_subformat_o));
            check_field("address", e_addr, packet_address_o);
            check_field("branches", 32'(e_cnt), 32'(packet_branches_o));
            check_field("branch_map", 32'(e_map), 32'(packet_branch_map_o));
            pkt_count++;
        end else if (exp_q.size() != 0) begin
            $display("%s: DUT sent no packet where the model expects one", test_name);
            exp_q.delete();
            err_count++;
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #5;
        check_output();
    endtask

    // weights in percent and the rest are normal instructions
    function automatic itype_e pick_itype(input int w_exc, input int w_br, input int w_jmp);
        int r;

        r = int'($urandom % 100);
        if (r < w_exc) begin
            return ITYPE_EXCEPTION;
        end
        if (r < w_exc + w_br) begin
            return ($urandom % 2) ? ITYPE_BRANCH_TAKEN : ITYPE_BRANCH_NOT_TAKEN;
        end
        if (r < w_exc + w_br + w_jmp) begin
            return ITYPE_UNINF_JUMP;
        end
        return ITYPE_NORMAL;
    endfunction

    task automatic run_test(input string name, input int idle, input int w_exc,
                            input int w_br, input int w_jmp, input int priv_pm,
                            input int qual_run);
        int     sent;
        int     err_start;
        int     pkt_start;
        itype_e itype;

        test_name   = name;
        err_start   = err_count;
        pkt_start   = pkt_count;
        sent        = 0;
        qualified_i = 1'b1;
        qual_left   = qual_run;
        repeat (idle) begin
            next_cycle();
            inst_valid_i = 1'b0;
        end
        while (sent < N_INSTR) begin
            next_cycle();
            inst_valid_i = ($urandom % 4) != 0;
            if (inst_valid_i) begin
                // qualification comes in long runs on and short runs off
                if (qual_run > 0) begin
                    if (qual_left == 0) begin
                        qualified_i = ~qualified_i;
                        qual_left   = qualified_i ? qual_run + int'($urandom % qual_run)
                                                  : 2 + int'($urandom % 8);
                    end
                    qual_left--;
                end
                if ($urandom % 1000 < priv_pm) begin
                    inst_priv_i = inst_priv_i + 2'd1;
                end
                itype        = pick_itype(w_exc, w_br, w_jmp);
                inst_iaddr_i = pc;
                inst_itype_i = itype;
                model_advance(pc, itype, inst_priv_i, qualified_i);
                if (itype == ITYPE_NORMAL || itype == ITYPE_BRANCH_NOT_TAKEN) begin
                    pc = pc + 32'd4;
                end else begin
                    pc = $urandom & 32'hffff_fffc;
                end
                sent++;
            end
        end
        // let the last instruction in and check the packet it decides
        next_cycle();
        inst_valid_i = 1'b0;
        if (err_count != err_start) begin
            tests_failed++;
        end
        $display("test %s done: %0d instructions, %0d packets, %0d errors", name, N_INSTR,
                 pkt_count - pkt_start, err_count - err_start);
    endtask

    initial begin
        rst_n_i      = 1'b0;
        inst_valid_i = 1'b0;
        inst_iaddr_i = '0;
        inst_itype_i = ITYPE_NORMAL;
        inst_priv_i  = '0;
        qualified_i  = 1'b0;
        err_count    = 0;
        pkt_count    = 0;
        tests_failed = 0;
        pc           = 32'h0000_1000;
        void'($urandom(32'h5d33fc14));
        model_reset();
        repeat (16) @(posedge clk);
        #5;
        rst_n_i = 1'b1;

        run_test("start_after_reset", 20, 3, 25, 5, 2, 150);
        run_test("exception_trap", 0, 15, 20, 5, 2, 150);
        run_test("uninferable_jump", 0, 0, 40, 15, 0, 200);
        run_test("branch_map_full", 0, 0, 97, 1, 0, 0);
        run_test("resync_period", 0, 0, 4, 0, 0, 0);
        run_test("qualification_toggle", 0, 3, 25, 5, 20, 12);

        $display("%0d tests, %0d failing, %0d packets checked, %0d errors",
                 N_TESTS, tests_failed, pkt_count, err_count);
        if (err_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* te_top.f */
+incdir+dv
verilog/te_trace_pkg.sv
verilog/te_packet_pkg.sv
verilog/te_stage_window.sv
verilog/te_priority.sv
verilog/te_resync_timer.sv
verilog/te_branch_map.sv
verilog/te_packet_emitter.sv
verilog/te_top.sv
dv/tb_te_top.sv

/* Makefile */
# Verilator build and run of the trace encoder testbench
VERILATOR ?= verilator
TOP       ?= tb_te_top
FILELIST  ?= te_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST)) dv/te_ref_model.svh
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(SIM) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "Test passed" $(LOG) || { echo "no result found in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
